// ==== load_unit.f ====
logic/load_pkg.sv
logic/load_buffer.sv
logic/load_request_fsm.sv
logic/load_result_align.sv
logic/load_unit.sv
bench/load_unit_checker.sv
bench/load_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the load unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
  -f load_unit.f --top-module load_unit_tb \
  -Mdir obj_dir -o load_unit_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/load_unit_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "simulation ended with an error, see sim.log"
  exit 1
fi

if grep -qxF '** PASS **' sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see sim.log"
  exit 1
fi

// ==== bench/load_unit_tb.sv ====
// testbench for the load unit with random loads, flushes and an out-of-order cache model
`timescale 1ns/1ps

module load_unit_tb;
  import load_pkg::*;

  localparam int n_loads     = 400;
  // about twenty cycles per load at most
  localparam int cycle_limit = 20 * n_loads;

  logic                  clk_i = 1'b0;
  logic                  rst_ni;
  logic                  flush_i;
  logic                  valid_i;
  logic [trans_id_w-1:0] trans_id_i;
  logic [vaddr_w-1:0]    vaddr_i;
  load_op_e              op_i;
  logic                  pop_o;
  logic                  req_o;
  logic [index_w-1:0]    index_o;
  size_e                 size_o;
  logic [ldbuf_id_w-1:0] id_o;
  logic                  gnt_i;
  logic                  tag_valid_o;
  logic [tag_w-1:0]      tag_o;
  logic                  kill_o;
  logic                  rvalid_i;
  logic [ldbuf_id_w-1:0] rid_i;
  logic [xlen-1:0]       rdata_i;
  logic                  valid_o;
  logic [trans_id_w-1:0] trans_id_o;
  logic [xlen-1:0]       result_o;

  // cache model, granted ids with their full address
  logic [ldbuf_id_w-1:0] q_id   [$];
  logic [vaddr_w-1:0]    q_addr [$];
  logic                  pend;
  logic [ldbuf_id_w-1:0] pend_id;
  logic [index_w-1:0]    pend_index;
  int                    resp_wait;
  // issue side
  logic                  popped;
  logic                  have_req;
  int                    accepted;
  int                    cycle_count = 0;
  int                    err_count;
  logic                  drain;

  always #4 clk_i = ~clk_i;

  load_unit uut (
    .clk_i, .rst_ni, .flush_i, .valid_i, .trans_id_i, .vaddr_i, .op_i, .pop_o,
    .req_o, .index_o, .size_o, .id_o, .gnt_i, .tag_valid_o, .tag_o, .kill_o,
    .rvalid_i, .rid_i, .rdata_i, .valid_o, .trans_id_o, .result_o
  );

  load_unit_checker u_checker (
    .clk_i, .rst_ni, .flush_i, .issue_tid_i(trans_id_i), .vaddr_i, .op_i,
    .pop_i(pop_o), .req_i(req_o), .index_i(index_o), .size_i(size_o), .id_i(id_o),
    .gnt_i, .tag_valid_i(tag_valid_o), .tag_i(tag_o), .kill_i(kill_o), .rvalid_i,
    .rid_i, .res_valid_i(valid_o), .res_tid_i(trans_id_o), .res_data_i(result_o),
    .drain_i(drain), .err_count_o(err_count)
  );

  // data word of the 8-byte line the address falls in
  function automatic logic [xlen-1:0] mix_word(logic [vaddr_w-1:0] addr);
    logic [31:0] a;
    a = {addr[31:3], 3'b000};
    return {a ^ 32'hc3a5_5a3c, (a * 32'h9e37_79b9) ^ (a >> 7)};
  endfunction

  // random kind with a size-aligned address
  task automatic next_load();
    logic [31:0]        r;
    logic [vaddr_w-1:0] addr;
    r    = $urandom;
    addr = $urandom;
    op_i = load_op_e'(3'(r % 32'd7));
    case (op_i)
      LD:       addr[2:0] = 3'b000;
      LW, LWU:  addr[1:0] = 2'b00;
      LH, LHU:  addr[0]   = 1'b0;
      default:  ;
    endcase
    vaddr_i  = addr;
    have_req = 1'b1;
  endtask

  // ------------------------------
  // posedge sampling
  // ------------------------------
  task automatic sample_outputs();
    // tag of last cycle's grant completes the queued address
    if (pend && tag_valid_o) begin
      q_id.push_back(pend_id);
      q_addr.push_back({tag_o, pend_index});
    end
    pend       = req_o && gnt_i;
    pend_id    = id_o;
    pend_index = index_o;
    popped     = pop_o;
    if (pop_o) begin
      accepted++;
    end
  endtask

  // ------------------------------
  // negedge driving
  // ------------------------------
  task automatic drive_inputs();
    int pick;
    gnt_i = ($urandom % 32'd10) < 32'd7;
    if (popped) begin
      trans_id_i = trans_id_i + 1'b1;
      have_req   = 1'b0;
    end
    if (!have_req && accepted < n_loads) begin
      next_load();
    end
    flush_i = ($urandom % 32'd40) == 32'd0;
    // pending load is held back in a flush cycle and offered again after
    valid_i = have_req && !flush_i;
    // answer one random queued request when the wait runs out
    rvalid_i = 1'b0;
    if (resp_wait > 0) begin
      resp_wait--;
    end
    if (resp_wait == 0 && q_id.size() != 0) begin
      pick     = int'($urandom % 32'(q_id.size()));
      rvalid_i = 1'b1;
      rid_i    = q_id[pick];
      rdata_i  = mix_word(q_addr[pick]);
      q_id.delete(pick);
      q_addr.delete(pick);
      resp_wait = 1 + int'($urandom % 32'd6);
    end
  endtask

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == cycle_limit) begin
      $display("timeout: run stopped after %0d cycles, %0d of %0d loads accepted",
               cycle_count, accepted, n_loads);
      $display("** FAIL **");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'h425c_2ffd));
    rst_ni     = 1'b0;
    flush_i    = 1'b0;
    valid_i    = 1'b0;
    trans_id_i = '0;
    vaddr_i    = '0;
    op_i       = LD;
    gnt_i      = 1'b0;
    rvalid_i   = 1'b0;
    rid_i      = '0;
    rdata_i    = '0;
    drain      = 1'b0;
    pend       = 1'b0;
    popped     = 1'b0;
    have_req   = 1'b0;
    resp_wait  = 0;
    accepted   = 0;
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;

    while (accepted < n_loads || have_req || pend || q_id.size() != 0) begin
      @(posedge clk_i);
      sample_outputs();
      @(negedge clk_i);
      drive_inputs();
    end

    // let the last response be seen, then ask for the drain check
    @(posedge clk_i);
    @(negedge clk_i);
    rvalid_i = 1'b0;
    flush_i  = 1'b0;
    valid_i  = 1'b0;
    drain    = 1'b1;
    @(posedge clk_i);
    @(negedge clk_i);
    drain = 1'b0;

    $display("errors: %0d, loads accepted: %0d, cycles: %0d", err_count, accepted, cycle_count);
    if (err_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== bench/load_unit_checker.sv ====
// checker comparing load unit results and cache handshakes with a reference model
`timescale 1ns/1ps

module load_unit_checker (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            flush_i,
  // issue side, as seen at the uut
  input  logic [load_pkg::trans_id_w-1:0] issue_tid_i,
  input  logic [load_pkg::vaddr_w-1:0]    vaddr_i,
  input  load_pkg::load_op_e              op_i,
  input  logic                            pop_i,
  // cache request side
  input  logic                            req_i,
  input  logic [load_pkg::index_w-1:0]    index_i,
  input  load_pkg::size_e                 size_i,
  input  logic [load_pkg::ldbuf_id_w-1:0] id_i,
  input  logic                            gnt_i,
  input  logic                            tag_valid_i,
  input  logic [load_pkg::tag_w-1:0]      tag_i,
  input  logic                            kill_i,
  // cache response and result
  input  logic                            rvalid_i,
  input  logic [load_pkg::ldbuf_id_w-1:0] rid_i,
  input  logic                            res_valid_i,
  input  logic [load_pkg::trans_id_w-1:0] res_tid_i,
  input  logic [load_pkg::xlen-1:0]       res_data_i,
  input  logic                            drain_i,
  output int                              err_count_o
);
  import load_pkg::*;

  // one record per request id, live until answered or flushed
  logic                  rec_live [nr_ldbuf];
  logic [trans_id_w-1:0] rec_tid  [nr_ldbuf];
  logic [vaddr_w-1:0]    rec_addr [nr_ldbuf];
  load_op_e              rec_op   [nr_ldbuf];
  // ids the cache still owes a response, flushed or not
  logic [nr_ldbuf-1:0]   busy;
  logic                  tag_due;
  logic                  kill_due;
  logic                  wait_req;
  logic [index_w-1:0]    index_q;
  logic [ldbuf_id_w-1:0] id_q;
  logic [tag_w-1:0]      tag_exp;
  int                    errors = 0;

  assign err_count_o = errors;

  // cache data for an address, same mixing as the cache model
  function automatic logic [xlen-1:0] mix_word(logic [vaddr_w-1:0] addr);
    logic [31:0] a;
    a = {addr[31:3], 3'b000};
    return {a ^ 32'hc3a5_5a3c, (a * 32'h9e37_79b9) ^ (a >> 7)};
  endfunction

  // shift down by the byte offset, then extend by kind
  function automatic logic [xlen-1:0] expect_result(logic [vaddr_w-1:0] addr, load_op_e op);
    logic [xlen-1:0] s;
    s = mix_word(addr) >> {addr[2:0], 3'b000};
    case (op)
      LW:      return {{32{s[31]}}, s[31:0]};
      LWU:     return {32'h0, s[31:0]};
      LH:      return {{48{s[15]}}, s[15:0]};
      LHU:     return {48'h0, s[15:0]};
      LB:      return {{56{s[7]}}, s[7:0]};
      LBU:     return {56'h0, s[7:0]};
      default: return s;
    endcase
  endfunction

  // size code the cache should see for each kind
  function automatic size_e size_for_kind(load_op_e op);
    case (op)
      LD:       return SIZE_DOUBLE;
      LW, LWU:  return SIZE_WORD;
      LH, LHU:  return SIZE_HALF;
      default:  return SIZE_BYTE;
    endcase
  endfunction

  task automatic report_value(string name, logic [xlen-1:0] exp_v, logic [xlen-1:0] got_v);
    $display("ERR %0t %s expected %h got %h", $time, name, exp_v, got_v);
    errors++;
  endtask

  task automatic report_text(string msg);
    $display("%0t: %s", $time, msg);
    errors++;
  endtask

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      if (req_i || pop_i || tag_valid_i || kill_i || res_valid_i) begin
        report_text("a handshake output is high during reset");
      end
      for (int i = 0; i < nr_ldbuf; i++) begin
        rec_live[i] = 1'b0;
      end
      busy     = '0;
      tag_due  = 1'b0;
      kill_due = 1'b0;
      wait_req = 1'b0;
    end else begin
      // ------------------------------
      // request and tag timing
      // ------------------------------
      if (kill_i !== kill_due) begin
        report_value("kill_o", 64'(kill_due), 64'(kill_i));
      end
      // tag phase follows a grant, or a flush as the kill cycle
      if (tag_valid_i !== (tag_due || kill_due)) begin
        report_value("tag_valid_o", 64'(tag_due || kill_due), 64'(tag_valid_i));
      end
      if (tag_due && tag_i !== tag_exp) begin
        report_value("tag_o", 64'(tag_exp), 64'(tag_i));
      end
      // request carries the low address bits and the size of the offered load
      if (req_i) begin
        if (index_i !== vaddr_i[index_w-1:0]) begin
          report_value("index_o", 64'(vaddr_i[index_w-1:0]), 64'(index_i));
        end
        if (size_i !== size_for_kind(op_i)) begin
          report_value("size_o", 64'(size_for_kind(op_i)), 64'(size_i));
        end
      end
      // ungranted request holds until grant or flush
      if (wait_req && !flush_i) begin
        if (!req_i) begin
          report_text("req_o dropped before its grant");
        end else begin
          if (index_i !== index_q) begin
            report_value("index_o", 64'(index_q), 64'(index_i));
          end
          if (id_i !== id_q) begin
            report_value("id_o", 64'(id_q), 64'(id_i));
          end
        end
      end
      if (&busy && !rvalid_i && req_i) begin
        report_text("req_o raised while all buffer entries are busy");
      end
      if (pop_i !== (req_i && gnt_i)) begin
        report_value("pop_o", 64'(req_i && gnt_i), 64'(pop_i));
      end

      // ------------------------------
      // responses and results
      // ------------------------------
      if (rvalid_i) begin
        if (!busy[rid_i]) begin
          report_text("cache answered an id with no request outstanding");
        end
        busy[rid_i] = 1'b0;
        if (rec_live[rid_i]) begin
          if (!res_valid_i) begin
            report_text("no result returned for a live load");
          end else begin
            if (res_tid_i !== rec_tid[rid_i]) begin
              report_value("trans_id_o", 64'(rec_tid[rid_i]), 64'(res_tid_i));
            end
            if (res_data_i !== expect_result(rec_addr[rid_i], rec_op[rid_i])) begin
              report_value("result_o", expect_result(rec_addr[rid_i], rec_op[rid_i]),
                           res_data_i);
            end
          end
          rec_live[rid_i] = 1'b0;
        end else if (res_valid_i) begin
          report_text("result returned for a flushed or unknown load");
        end
      end else if (res_valid_i) begin
        report_text("valid_o raised without a cache response");
      end

      // flush cancels every load accepted so far
      if (flush_i) begin
        for (int i = 0; i < nr_ldbuf; i++) begin
          rec_live[i] = 1'b0;
        end
      end
      if (pop_i) begin
        if (busy[id_i]) begin
          report_text("id_o reused while its load is outstanding");
        end
        busy[id_i]     = 1'b1;
        rec_live[id_i] = 1'b1;
        rec_tid[id_i]  = issue_tid_i;
        rec_addr[id_i] = vaddr_i;
        rec_op[id_i]   = op_i;
      end

      kill_due = flush_i;
      tag_due  = pop_i;
      tag_exp  = vaddr_i[vaddr_w-1:index_w];
      wait_req = req_i && !gnt_i;
      index_q  = index_i;
      id_q     = id_i;

      // every load must be answered by the end
      if (drain_i && busy != '0) begin
        report_text("loads still outstanding at the end of the run");
      end
    end
  end

endmodule

// ==== logic/load_unit.sv ====
// data-cache load unit with up to four outstanding loads and out-of-order responses
`timescale 1ns/1ps

module load_unit (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             flush_i,
  // issue queue
  input  logic                             valid_i,
  input  logic [load_pkg::trans_id_w-1:0]  trans_id_i,
  input  logic [load_pkg::vaddr_w-1:0]     vaddr_i,
  input  load_pkg::load_op_e               op_i,
  output logic                             pop_o,
  // cache request
  output logic                             req_o,
  output logic [load_pkg::index_w-1:0]     index_o,
  output load_pkg::size_e                  size_o,
  output logic [load_pkg::ldbuf_id_w-1:0]  id_o,
  input  logic                             gnt_i,
  output logic                             tag_valid_o,
  output logic [load_pkg::tag_w-1:0]       tag_o,
  output logic                             kill_o,
  // cache response
  input  logic                             rvalid_i,
  input  logic [load_pkg::ldbuf_id_w-1:0]  rid_i,
  input  logic [load_pkg::xlen-1:0]        rdata_i,
  // result to issue stage
  output logic                             valid_o,
  output logic [load_pkg::trans_id_w-1:0]  trans_id_o,
  output logic [load_pkg::xlen-1:0]        result_o
);
  import load_pkg::*;

  logic                  ldbuf_full;
  logic                  ldbuf_write;
  logic [ldbuf_id_w-1:0] free_id;
  ldbuf_entry_t          rd_entry;
  logic                  rd_live;

  // ------------------------------
  // request path
  // ------------------------------
  load_request_fsm u_request_fsm (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .valid_i       (valid_i),
    .vaddr_i       (vaddr_i),
    .op_i          (op_i),
    .ldbuf_full_i  (ldbuf_full),
    .gnt_i         (gnt_i),
    .pop_o         (pop_o),
    .req_o         (req_o),
    .index_o       (index_o),
    .size_o        (size_o),
    .tag_valid_o   (tag_valid_o),
    .tag_o         (tag_o),
    .kill_o        (kill_o),
    .ldbuf_write_o (ldbuf_write)
  );

  // request id is the buffer slot that will hold the load
  assign id_o = free_id;

  load_buffer u_load_buffer (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .flush_i    (flush_i),
    .write_i    (ldbuf_write),
    .trans_id_i (trans_id_i),
    .vaddr_i    (vaddr_i),
    .op_i       (op_i),
    .rvalid_i   (rvalid_i),
    .rid_i      (rid_i),
    .full_o     (ldbuf_full),
    .free_id_o  (free_id),
    .rd_entry_o (rd_entry),
    .rd_live_o  (rd_live)
  );

  // ------------------------------
  // response path
  // ------------------------------
  load_result_align u_result_align (
    .rdata_i  (rdata_i),
    .entry_i  (rd_entry),
    .result_o (result_o)
  );

  // flushed loads still free their slot but produce no result
  assign valid_o    = rd_live;
  assign trans_id_o = rd_entry.trans_id;

endmodule

// ==== logic/load_result_align.sv ====
// result aligner shifting the response word and sign or zero extending it per load kind
`timescale 1ns/1ps

module load_result_align (
  input  logic [load_pkg::xlen-1:0]  rdata_i,
  input  load_pkg::ldbuf_entry_t     entry_i,
  output logic [load_pkg::xlen-1:0]  result_o
);
  import load_pkg::*;

  logic [xlen-1:0]     shifted;
  logic [xlen/8-1:0]   sign_bits;
  logic [offset_w-1:0] sign_pos;
  logic                is_signed;
  logic                sign_bit;

  // ------------------------------
  // byte shift
  // ------------------------------
  // offset in bytes, times eight
  assign shifted = rdata_i >> {entry_i.offset, 3'b000};

  // ------------------------------
  // sign bit, beside the shifter
  // ------------------------------
  // top bit of every byte lane in the raw word
  for (genvar i = 0; i < xlen / 8; i++) begin : gen_sign_bits
    assign sign_bits[i] = rdata_i[i*8+7];
  end

  assign is_signed = entry_i.op inside {LW, LH, LB};

  // lane holding the most significant byte of the loaded value
  always_comb begin
    unique case (entry_i.op)
      LW:      sign_pos = entry_i.offset + offset_w'(3);
      LH:      sign_pos = entry_i.offset + offset_w'(1);
      default: sign_pos = entry_i.offset;
    endcase
  end

  // unsigned kinds pull the fill to zero
  assign sign_bit = is_signed & sign_bits[sign_pos];

  // ------------------------------
  // result mux
  // ------------------------------
  always_comb begin
    unique case (entry_i.op)
      LW, LWU: result_o = {{(xlen - 32){sign_bit}}, shifted[31:0]};
      LH, LHU: result_o = {{(xlen - 16){sign_bit}}, shifted[15:0]};
      LB, LBU: result_o = {{(xlen - 8){sign_bit}}, shifted[7:0]};
      // full double word
      default: result_o = shifted;
    endcase
  end

endmodule

// ==== logic/load_request_fsm.sv ====
// request FSM driving index, grant wait, tag phase and flush kill towards the cache
`timescale 1ns/1ps

module load_request_fsm (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             flush_i,
  // issue side
  input  logic                             valid_i,
  input  logic [load_pkg::vaddr_w-1:0]     vaddr_i,
  input  load_pkg::load_op_e               op_i,
  input  logic                             ldbuf_full_i,
  input  logic                             gnt_i,
  output logic                             pop_o,
  // cache request side
  output logic                             req_o,
  output logic [load_pkg::index_w-1:0]     index_o,
  output load_pkg::size_e                  size_o,
  output logic                             tag_valid_o,
  output logic [load_pkg::tag_w-1:0]       tag_o,
  output logic                             kill_o,
  output logic                             ldbuf_write_o
);
  import load_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    WAIT_GNT,
    SEND_TAG,
    FLUSH_KILL
  } state_e;

  state_e             state_q, state_d;
  logic               accept;
  logic               granted;
  logic [tag_w-1:0]   tag_q;

  // new load can start only with a free slot and no flush
  assign accept = valid_i && !ldbuf_full_i && !flush_i;

  // index and size come straight from the issue queue, which holds them until the pop
  assign index_o = vaddr_i[index_w-1:0];
  assign size_o  = op_size(op_i);

  // ------------------------------
  // next state and request control
  // ------------------------------
  always_comb begin
    state_d     = state_q;
    req_o       = 1'b0;
    tag_valid_o = 1'b0;
    kill_o      = 1'b0;

    unique case (state_q)
      IDLE: begin
        if (accept) begin
          req_o   = 1'b1;
          state_d = gnt_i ? SEND_TAG : WAIT_GNT;
        end
      end

      WAIT_GNT: begin
        // hold the request, withdrawn only by a flush
        req_o = !flush_i;
        if (gnt_i) begin
          state_d = SEND_TAG;
        end
      end

      SEND_TAG: begin
        tag_valid_o = 1'b1;
        state_d     = IDLE;
        // back-to-back load in the tag cycle
        if (accept) begin
          req_o   = 1'b1;
          state_d = gnt_i ? SEND_TAG : WAIT_GNT;
        end
      end

      FLUSH_KILL: begin
        // cache drops whatever request is in its tag phase
        kill_o      = 1'b1;
        tag_valid_o = 1'b1;
        state_d     = IDLE;
      end

      default: begin
        state_d = IDLE;
      end
    endcase

    // flush wins over every other transition
    if (flush_i) begin
      state_d = FLUSH_KILL;
    end
  end

  assign granted       = req_o && gnt_i;
  assign pop_o         = granted;
  assign ldbuf_write_o = granted;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ------------------------------
  // tag capture
  // ------------------------------
  // upper address bits of the granted load for the following cycle
  always_ff @(posedge clk_i) begin
    if (granted) begin
      tag_q <= vaddr_i[vaddr_w-1:index_w];
    end
  end

  assign tag_o = tag_q;

endmodule

// ==== logic/load_buffer.sv ====
// load buffer tracking outstanding loads by request id, with flushed flags
`timescale 1ns/1ps

module load_buffer (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               flush_i,
  // write side, one write per granted request
  input  logic                               write_i,
  input  logic [load_pkg::trans_id_w-1:0]    trans_id_i,
  input  logic [load_pkg::vaddr_w-1:0]       vaddr_i,
  input  load_pkg::load_op_e                 op_i,
  // response side
  input  logic                               rvalid_i,
  input  logic [load_pkg::ldbuf_id_w-1:0]    rid_i,
  output logic                               full_o,
  output logic [load_pkg::ldbuf_id_w-1:0]    free_id_o,
  output load_pkg::ldbuf_entry_t             rd_entry_o,
  output logic                               rd_live_o
);
  import load_pkg::*;

  logic [nr_ldbuf-1:0]   valid_q, valid_d;
  logic [nr_ldbuf-1:0]   flushed_q, flushed_d;
  ldbuf_entry_t          entry_q [nr_ldbuf];
  logic [nr_ldbuf-1:0]   release_mask;
  logic [nr_ldbuf-1:0]   avail;
  logic [ldbuf_id_w-1:0] lowest_free;
  logic [ldbuf_id_w-1:0] pick_q;

  // ------------------------------
  // free slot choice
  // ------------------------------
  // a response this cycle already frees its slot for a new request
  always_comb begin
    release_mask = '0;
    if (rvalid_i) begin
      release_mask[rid_i] = 1'b1;
    end
  end

  assign avail  = ~valid_q | release_mask;
  assign full_o = ~|avail;

  // lowest free slot
  always_comb begin
    lowest_free = '0;
    for (int i = nr_ldbuf - 1; i >= 0; i--) begin
      if (avail[i]) begin
        lowest_free = ldbuf_id_w'(i);
      end
    end
  end

  // keep the last choice while it is still free, so the id holds during a grant wait
  assign free_id_o = !valid_q[pick_q] ? pick_q : lowest_free;

  // ------------------------------
  // valid and flushed flags
  // ------------------------------
  always_comb begin
    valid_d   = valid_q;
    flushed_d = flushed_q;
    // every outstanding load is cancelled by a flush
    if (flush_i) begin
      flushed_d = '1;
    end
    if (rvalid_i) begin
      valid_d[rid_i] = 1'b0;
    end
    // a new load is live even in a flush cycle
    if (write_i) begin
      valid_d[free_id_o]   = 1'b1;
      flushed_d[free_id_o] = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q   <= '0;
      flushed_q <= '0;
      pick_q    <= '0;
    end else begin
      valid_q   <= valid_d;
      flushed_q <= flushed_d;
      pick_q    <= free_id_o;
    end
  end

  // entry payload
  always_ff @(posedge clk_i) begin
    if (write_i) begin
      entry_q[free_id_o] <= '{trans_id: trans_id_i, offset: vaddr_i[offset_w-1:0], op: op_i};
    end
  end

  // ------------------------------
  // read port by response id
  // ------------------------------
  assign rd_entry_o = entry_q[rid_i];
  assign rd_live_o  = rvalid_i && valid_q[rid_i] && !flushed_q[rid_i];

endmodule

// ==== logic/load_pkg.sv ====
// load unit package with widths, buffer depth, load kinds and the buffer entry type
package load_pkg;

  // ------------------------------
  // widths
  // ------------------------------
  localparam int unsigned xlen       = 64;
  localparam int unsigned vaddr_w    = 32;
  // low address bits, presented in the request cycle
  localparam int unsigned index_w    = 12;
  // remaining upper bits, presented in the tag cycle
  localparam int unsigned tag_w      = vaddr_w - index_w;
  localparam int unsigned trans_id_w = 3;
  localparam int unsigned nr_ldbuf   = 4;
  localparam int unsigned ldbuf_id_w = $clog2(nr_ldbuf);
  // byte position inside one 64-bit data word
  localparam int unsigned offset_w   = 3;

  // ------------------------------
  // load kinds and size codes
  // ------------------------------
  typedef enum logic [2:0] {
    LD  = 3'd0,
    LW  = 3'd1,
    LWU = 3'd2,
    LH  = 3'd3,
    LHU = 3'd4,
    LB  = 3'd5,
    LBU = 3'd6
  } load_op_e;

  // size code as the cache expects it
  typedef enum logic [1:0] {
    SIZE_BYTE   = 2'd0,
    SIZE_HALF   = 2'd1,
    SIZE_WORD   = 2'd2,
    SIZE_DOUBLE = 2'd3
  } size_e;

  // one outstanding load, 9 bits
  typedef struct packed {
    logic [trans_id_w-1:0] trans_id;
    logic [offset_w-1:0]   offset;
    load_op_e              op;
  } ldbuf_entry_t;

  // transfer size for a load kind
  function automatic size_e op_size(load_op_e op);
    unique case (op)
      LD:       return SIZE_DOUBLE;
      LW, LWU:  return SIZE_WORD;
      LH, LHU:  return SIZE_HALF;
      default:  return SIZE_BYTE;
    endcase
  endfunction

endpackage
